// ==== src/relobi_mux_pkg.sv ====
// *********************************************************************
// Reliable OBI multiplexer package: widths, OBI channel structs and
// the SEC-DED code that protects the stored response routing index.
// *********************************************************************

package relobi_mux_pkg;

  localparam int unsigned NumPorts  = 4;
  localparam int unsigned IdxWidth  = 2;
  localparam int unsigned EccWidth  = 4;
  localparam int unsigned CodeWidth = IdxWidth + EccWidth;
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned BeWidth   = DataWidth / 8;
  localparam int unsigned IdWidth   = 4;
  localparam int unsigned MaxTrans  = 4;
  localparam int unsigned PtrWidth  = $clog2(MaxTrans);
  localparam int unsigned CntWidth  = $clog2(MaxTrans + 1);

  typedef logic [IdxWidth-1:0]  idx_t;
  typedef logic [CodeWidth-1:0] code_t;

  typedef struct packed {
    logic [AddrWidth-1:0] addr;
    logic                 we;
    logic [BeWidth-1:0]   be;
    logic [DataWidth-1:0] wdata;
    logic [IdWidth-1:0]   aid;
  } obi_a_chan_t;

  typedef struct packed {
    logic        req;
    obi_a_chan_t a;
  } obi_req_t;

  typedef struct packed {
    logic [DataWidth-1:0] rdata;
    logic [IdWidth-1:0]   rid;
    logic                 err;
  } obi_r_chan_t;

  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    obi_r_chan_t r;
  } obi_rsp_t;

  typedef struct packed {
    idx_t idx;
    logic corr;
    logic uncorr;
  } ecc_dec_t;

  // Extended Hamming code for a two-bit index. Bits 4:0 hold Hamming
  // positions 1 to 5, bit 5 holds the overall parity.
  function automatic code_t ecc_encode(idx_t idx);
    code_t code;
    code[0] = idx[0] ^ idx[1];
    code[1] = idx[0];
    code[2] = idx[0];
    code[3] = idx[1];
    code[4] = idx[1];
    code[5] = ^code[4:0];
    return code;
  endfunction

  function automatic ecc_dec_t ecc_decode(code_t code);
    ecc_dec_t   res;
    logic [2:0] syn;
    logic       par;
    code_t      fixed;
    syn[0]     = code[0] ^ code[2] ^ code[4];
    syn[1]     = code[1] ^ code[2];
    syn[2]     = code[3] ^ code[4];
    par        = ^code;
    fixed      = code;
    res.corr   = 1'b0;
    res.uncorr = 1'b0;
    if (par) begin
      // Odd parity means one flipped bit, unless it points past position 5.
      if (syn == 3'd0) begin
        res.corr = 1'b1;
      end else if (syn <= 3'd5) begin
        fixed[syn - 3'd1] = ~fixed[syn - 3'd1];
        res.corr          = 1'b1;
      end else begin
        res.uncorr = 1'b1;
      end
    end else if (syn != 3'd0) begin
      res.uncorr = 1'b1;
    end
    res.idx = {fixed[4], fixed[2]};
    return res;
  endfunction

endpackage

// ==== src/tmr_voter.sv ====
// *********************************************************************
// Bitwise majority voter over three copies of a payload, with a flag
// raised whenever the copies disagree.
// *********************************************************************

`timescale 1ns/10ps

module tmr_voter #(
  parameter type payload_t = logic
) (
  input  payload_t a_i,
  input  payload_t b_i,
  input  payload_t c_i,
  output payload_t vote_o,
  output logic     fault_o
);

  // Two out of three copies win on every bit.
  assign vote_o = (a_i & b_i) | (a_i & c_i) | (b_i & c_i);

  assign fault_o = (a_i != b_i) || (a_i != c_i);

endmodule

// ==== src/rr_arbiter.sv ====
// *********************************************************************
// Round-robin arbiter with lock-in. Picks one requesting subordinate
// and forwards its A channel until the manager side grants it.
// *********************************************************************

`timescale 1ns/10ps

module rr_arbiter (
  input  logic                                                 clk_i,
  input  logic                                                 rst_i,
  input  logic [relobi_mux_pkg::NumPorts-1:0]                  req_i,
  input  relobi_mux_pkg::obi_a_chan_t [relobi_mux_pkg::NumPorts-1:0] data_i,
  output logic [relobi_mux_pkg::NumPorts-1:0]                  gnt_o,
  output logic                                                 req_o,
  output relobi_mux_pkg::obi_a_chan_t                          data_o,
  input  logic                                                 gnt_i,
  output relobi_mux_pkg::idx_t                                 idx_o
);

  relobi_mux_pkg::idx_t prio_q;
  relobi_mux_pkg::idx_t lock_idx_q;
  relobi_mux_pkg::idx_t pick;
  relobi_mux_pkg::idx_t next_prio;
  logic                 lock_q;

  // First requesting port at or after the priority pointer.
  always_comb begin
    relobi_mux_pkg::idx_t cand;
    logic                 found;
    pick  = prio_q;
    found = 1'b0;
    for (int i = 0; i < relobi_mux_pkg::NumPorts; i++) begin
      cand = relobi_mux_pkg::idx_t'((int'(prio_q) + i) % relobi_mux_pkg::NumPorts);
      if (!found && req_i[cand]) begin
        pick  = cand;
        found = 1'b1;
      end
    end
  end

  // A pending request keeps its slot until granted.
  assign idx_o  = lock_q ? lock_idx_q : pick;
  assign req_o  = req_i[idx_o];
  assign data_o = data_i[idx_o];

  always_comb begin
    gnt_o        = '0;
    gnt_o[idx_o] = req_o & gnt_i;
  end

  assign next_prio =
    relobi_mux_pkg::idx_t'((int'(idx_o) + 1) % relobi_mux_pkg::NumPorts);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      prio_q     <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else begin
      if (req_o && !gnt_i) begin
        lock_q     <= 1'b1;
        lock_idx_q <= idx_o;
      end else begin
        lock_q <= 1'b0;
      end
      if (req_o && gnt_i) begin
        prio_q <= next_prio;
      end
    end
  end

endmodule

// ==== src/index_fifo.sv ====
// *********************************************************************
// In-order FIFO of encoded port indices, one entry per outstanding
// request. Entries keep their check bits while stored.
// *********************************************************************

`timescale 1ns/10ps

module index_fifo (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  push_i,
  input  relobi_mux_pkg::code_t data_i,
  input  logic                  pop_i,
  output relobi_mux_pkg::code_t data_o,
  output logic                  full_o
);

  relobi_mux_pkg::code_t                   mem_q [relobi_mux_pkg::MaxTrans];
  logic [relobi_mux_pkg::PtrWidth-1:0]     wptr_q;
  logic [relobi_mux_pkg::PtrWidth-1:0]     rptr_q;
  logic [relobi_mux_pkg::CntWidth-1:0]     count_q;
  logic                                    empty;
  logic                                    do_push;
  logic                                    do_pop;

  assign full_o  = (count_q == relobi_mux_pkg::CntWidth'(relobi_mux_pkg::MaxTrans));
  assign empty   = (count_q == '0);
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty;

  // Head is read straight from storage, so a push shows up a cycle later.
  assign data_o = mem_q[rptr_q];

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (do_push) begin
        wptr_q <= (wptr_q == relobi_mux_pkg::PtrWidth'(relobi_mux_pkg::MaxTrans - 1)) ?
                  '0 : wptr_q + 1'b1;
      end
      if (do_pop) begin
        rptr_q <= (rptr_q == relobi_mux_pkg::PtrWidth'(relobi_mux_pkg::MaxTrans - 1)) ?
                  '0 : rptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

// ==== src/route_lane.sv ====
// *********************************************************************
// One response routing lane. Encodes the granted port index and steers
// rvalid to the port named by the decoded FIFO head.
// *********************************************************************

`timescale 1ns/10ps

module route_lane (
  input  relobi_mux_pkg::idx_t                sel_idx_i,
  output relobi_mux_pkg::code_t               sel_code_o,
  input  relobi_mux_pkg::code_t               head_code_i,
  input  logic                                rvalid_i,
  output logic [relobi_mux_pkg::NumPorts-1:0] rvalid_o,
  output logic                                corr_o,
  output logic                                uncorr_o
);

  relobi_mux_pkg::ecc_dec_t head_dec;

  assign sel_code_o = relobi_mux_pkg::ecc_encode(sel_idx_i);
  assign head_dec   = relobi_mux_pkg::ecc_decode(head_code_i);

  always_comb begin
    rvalid_o               = '0;
    rvalid_o[head_dec.idx] = rvalid_i;
  end

  // The head only means something while a response is popping it.
  assign corr_o   = rvalid_i & head_dec.corr;
  assign uncorr_o = rvalid_i & head_dec.uncorr;

endmodule

// ==== src/relobi_mux.sv ====
// *********************************************************************
// Fault-tolerant OBI multiplexer. Arbitrates four subordinate ports
// onto one manager port and routes responses through three voted lanes.
// *********************************************************************

`timescale 1ns/10ps

module relobi_mux (
  input  logic                                                clk_i,
  input  logic                                                rst_i,
  input  relobi_mux_pkg::obi_req_t [relobi_mux_pkg::NumPorts-1:0] sbr_req_i,
  output relobi_mux_pkg::obi_rsp_t [relobi_mux_pkg::NumPorts-1:0] sbr_rsp_o,
  output relobi_mux_pkg::obi_req_t                            mgr_req_o,
  input  relobi_mux_pkg::obi_rsp_t                            mgr_rsp_i,
  output logic [1:0]                                          fault_o
);

  logic [relobi_mux_pkg::NumPorts-1:0]                  sbr_req;
  logic [relobi_mux_pkg::NumPorts-1:0]                  sbr_gnt;
  relobi_mux_pkg::obi_a_chan_t [relobi_mux_pkg::NumPorts-1:0] sbr_a;
  relobi_mux_pkg::obi_a_chan_t                          mgr_a;
  logic                                                 arb_req;
  logic                                                 arb_gnt;
  relobi_mux_pkg::idx_t                                 sel_idx;
  logic                                                 fifo_full;
  logic                                                 fifo_push;
  relobi_mux_pkg::code_t [2:0]                          sel_code;
  relobi_mux_pkg::code_t                                push_code;
  relobi_mux_pkg::code_t                                head_code;
  logic [2:0][relobi_mux_pkg::NumPorts-1:0]             lane_rvalid;
  logic [relobi_mux_pkg::NumPorts-1:0]                  rvalid_vote;
  logic [2:0]                                           lane_corr;
  logic [2:0]                                           lane_uncorr;
  logic                                                 code_fault;
  logic                                                 rvalid_fault;

  for (genvar i = 0; i < relobi_mux_pkg::NumPorts; i++) begin : gen_ports
    assign sbr_req[i]          = sbr_req_i[i].req;
    assign sbr_a[i]            = sbr_req_i[i].a;
    assign sbr_rsp_o[i].gnt    = sbr_gnt[i];
    assign sbr_rsp_o[i].rvalid = rvalid_vote[i];
    // All ports see the same R payload, only rvalid is steered.
    assign sbr_rsp_o[i].r      = mgr_rsp_i.r;
  end

  // No new request leaves while every FIFO slot is taken.
  assign mgr_req_o.req = arb_req & ~fifo_full;
  assign mgr_req_o.a   = mgr_a;
  assign arb_gnt       = mgr_rsp_i.gnt & ~fifo_full;
  assign fifo_push     = mgr_req_o.req & mgr_rsp_i.gnt;

  rr_arbiter i_arb (
    .clk_i  ( clk_i     ),
    .rst_i  ( rst_i     ),
    .req_i  ( sbr_req   ),
    .data_i ( sbr_a     ),
    .gnt_o  ( sbr_gnt   ),
    .req_o  ( arb_req   ),
    .data_o ( mgr_a     ),
    .gnt_i  ( arb_gnt   ),
    .idx_o  ( sel_idx   )
  );

  for (genvar i = 0; i < 3; i++) begin : gen_lanes
    route_lane i_lane (
      .sel_idx_i   ( sel_idx          ),
      .sel_code_o  ( sel_code[i]      ),
      .head_code_i ( head_code        ),
      .rvalid_i    ( mgr_rsp_i.rvalid ),
      .rvalid_o    ( lane_rvalid[i]   ),
      .corr_o      ( lane_corr[i]     ),
      .uncorr_o    ( lane_uncorr[i]   )
    );
  end

  tmr_voter #(
    .payload_t ( relobi_mux_pkg::code_t )
  ) i_code_vote (
    .a_i     ( sel_code[0] ),
    .b_i     ( sel_code[1] ),
    .c_i     ( sel_code[2] ),
    .vote_o  ( push_code   ),
    .fault_o ( code_fault  )
  );

  index_fifo i_fifo (
    .clk_i  ( clk_i            ),
    .rst_i  ( rst_i            ),
    .push_i ( fifo_push        ),
    .data_i ( push_code        ),
    .pop_i  ( mgr_rsp_i.rvalid ),
    .data_o ( head_code        ),
    .full_o ( fifo_full        )
  );

  tmr_voter #(
    .payload_t ( logic [relobi_mux_pkg::NumPorts-1:0] )
  ) i_rvalid_vote (
    .a_i     ( lane_rvalid[0] ),
    .b_i     ( lane_rvalid[1] ),
    .c_i     ( lane_rvalid[2] ),
    .vote_o  ( rvalid_vote    ),
    .fault_o ( rvalid_fault   )
  );

  assign fault_o[0] = code_fault | rvalid_fault | (|lane_corr);
  assign fault_o[1] = |lane_uncorr;

endmodule

// ==== test/relobi_mux_asserts.sv ====
// *********************************************************************
// Protocol assertions for the reliable OBI multiplexer, bound into the
// top level. A shadow count of accepted requests tracks FIFO occupancy.
// *********************************************************************

`timescale 1ns/10ps

module relobi_mux_asserts (
  input logic                                                 clk_i,
  input logic                                                 rst_i,
  input relobi_mux_pkg::obi_req_t [relobi_mux_pkg::NumPorts-1:0] sbr_req_i,
  input relobi_mux_pkg::obi_rsp_t [relobi_mux_pkg::NumPorts-1:0] sbr_rsp_o,
  input relobi_mux_pkg::obi_req_t                             mgr_req_o,
  input relobi_mux_pkg::obi_rsp_t                             mgr_rsp_i
);

  logic [relobi_mux_pkg::NumPorts-1:0] gnt_vec;
  logic [relobi_mux_pkg::NumPorts-1:0] rvalid_vec;
  logic [2:0]                          outstanding_q;

  always_comb begin
    for (int p = 0; p < relobi_mux_pkg::NumPorts; p++) begin
      gnt_vec[p]    = sbr_rsp_o[p].gnt;
      rvalid_vec[p] = sbr_rsp_o[p].rvalid;
    end
  end

  // Shadow occupancy of the index FIFO.
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      outstanding_q <= '0;
    end else begin
      outstanding_q <= outstanding_q + 3'(mgr_req_o.req & mgr_rsp_i.gnt)
                       - 3'(mgr_rsp_i.rvalid);
    end
  end

  for (genvar p = 0; p < relobi_mux_pkg::NumPorts; p++) begin : gen_stable
    assert property (@(posedge clk_i) disable iff (rst_i)
      sbr_req_i[p].req && !sbr_rsp_o[p].gnt |=> sbr_req_i[p].req && $stable(sbr_req_i[p].a))
      else $error("request on a port changed before its grant");
  end

  assert property (@(posedge clk_i) disable iff (rst_i) $onehot0(gnt_vec))
    else $error("more than one port granted in a cycle");

  assert property (@(posedge clk_i) disable iff (rst_i) $onehot0(rvalid_vec))
    else $error("more than one port saw rvalid in a cycle");

  assert property (@(posedge clk_i) disable iff (rst_i)
    mgr_rsp_i.rvalid |-> outstanding_q != 3'd0)
    else $error("response arrived with the index FIFO empty");

  assert property (@(posedge clk_i) disable iff (rst_i)
    mgr_req_o.req |-> outstanding_q != 3'(relobi_mux_pkg::MaxTrans))
    else $error("manager request raised while the index FIFO is full");

endmodule

bind relobi_mux relobi_mux_asserts i_asserts (
  .clk_i       ( clk_i     ),
  .rst_i       ( rst_i     ),
  .sbr_req_i   ( sbr_req_i ),
  .sbr_rsp_o   ( sbr_rsp_o ),
  .mgr_req_o   ( mgr_req_o ),
  .mgr_rsp_i   ( mgr_rsp_i )
);

// ==== test/tb_relobi_mux.sv ====
// *********************************************************************
// Testbench for the reliable OBI multiplexer: port drivers, a memory
// model on the manager side and an in-order response checker.
// *********************************************************************

`timescale 1ns/10ps

module tb_relobi_mux;

  localparam int Timeout = 400;

  logic                                                 clk_i;
  logic                                                 rst_i;
  relobi_mux_pkg::obi_req_t [relobi_mux_pkg::NumPorts-1:0] sbr_req;
  relobi_mux_pkg::obi_rsp_t [relobi_mux_pkg::NumPorts-1:0] sbr_rsp;
  relobi_mux_pkg::obi_req_t                             mgr_req;
  relobi_mux_pkg::obi_rsp_t                             mgr_rsp;
  logic [1:0]                                           fault;

  integer      seed = 32646;
  int          err_count = 0;
  int          timeout_count = 0;
  string       test_name = "reset";
  logic        rst_done = 1'b0;
  int          gnt_mode = 2;  // 0 random, 1 always, 2 never
  logic        resp_hold = 1'b0;
  int          cycle = 0;
  int          last_gnt = 3;
  int          grant_log[$];
  int          exp_port_q[$];
  logic [3:0]  exp_rid_q[$];
  logic [31:0] exp_rdata_q[$];
  logic [31:0] shadow[int];
  logic [31:0] mem_words[int];
  logic [31:0] rsp_rdata_q[$];
  logic [3:0]  rsp_rid_q[$];
  int          rsp_ready_q[$];

  relobi_mux dut0 (
    .clk_i     ( clk_i   ),
    .rst_i     ( rst_i   ),
    .sbr_req_i ( sbr_req ),
    .sbr_rsp_o ( sbr_rsp ),
    .mgr_req_o ( mgr_req ),
    .mgr_rsp_i ( mgr_rsp ),
    .fault_o   ( fault   )
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  function automatic logic [31:0] rand_word();
    return $random(seed);
  endfunction

  // Unwritten words read back a pattern built from the full address.
  function automatic logic [31:0] fill_word(logic [31:0] addr);
    return addr ^ {addr[15:0], addr[31:16]} ^ 32'h3c3c_c3c3;
  endfunction

  function automatic logic [31:0] merge_be(logic [31:0] old, logic [31:0] wd, logic [3:0] be);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) res[8*b +: 8] = wd[8*b +: 8];
    end
    return res;
  endfunction

  // Expected rdata of a request, applied to the shadow memory in issue order.
  function automatic logic [31:0] ref_rdata(relobi_mux_pkg::obi_a_chan_t a);
    int          key;
    logic [31:0] cur;
    key = int'(a.addr[31:2]);
    cur = shadow.exists(key) ? shadow[key] : fill_word({a.addr[31:2], 2'b00});
    if (a.we) begin
      shadow[key] = merge_be(cur, a.wdata, a.be);
      return 32'h0;
    end
    return cur;
  endfunction

  task automatic check_value(string what, logic [63:0] exp, logic [63:0] act);
    if (exp != act) begin
      $display("[ERROR] %s %s: expected %0h, actual %0h", test_name, what, exp, act);
      err_count++;
    end
  endtask

  task automatic check_idle();
    for (int p = 0; p < relobi_mux_pkg::NumPorts; p++) begin
      check_value($sformatf("gnt[%0d]", p), 0, 64'(sbr_rsp[p].gnt));
      check_value($sformatf("rvalid[%0d]", p), 0, 64'(sbr_rsp[p].rvalid));
    end
    check_value("mgr req", 0, 64'(mgr_req.req));
    check_value("fault", 0, 64'(fault));
  endtask

  // Caller is 2 ns past a rising edge; returns at the same phase.
  task automatic issue_req(int p, relobi_mux_pkg::obi_a_chan_t a);
    int   n;
    logic granted;
    sbr_req[p].req = 1'b1;
    sbr_req[p].a   = a;
    n       = 0;
    granted = 1'b0;
    while (!granted && n < Timeout) begin
      @(negedge clk_i);
      granted = sbr_rsp[p].gnt;
      n++;
    end
    if (!granted) begin
      $display("Timed out waiting for a grant on port %0d in %s", p, test_name);
      timeout_count++;
    end
    @(posedge clk_i);
    #2;
    sbr_req[p].req = 1'b0;
  endtask

  function automatic relobi_mux_pkg::obi_a_chan_t make_a(logic we, logic [31:0] addr,
                                                         logic [31:0] wd, logic [3:0] be,
                                                         logic [3:0] aid);
    relobi_mux_pkg::obi_a_chan_t a;
    a.addr  = addr;
    a.we    = we;
    a.be    = be;
    a.wdata = wd;
    a.aid   = aid;
    return a;
  endfunction

  task automatic drain_wait();
    int n;
    n = 0;
    while ((exp_port_q.size() != 0 || rsp_ready_q.size() != 0) && n < Timeout) begin
      @(negedge clk_i);
      n++;
    end
    if (n >= Timeout) begin
      $display("Timed out waiting for outstanding responses in %s", test_name);
      timeout_count++;
    end
  endtask

  task automatic port_random(int p, int count);
    logic [31:0] r;
    @(posedge clk_i);
    #2;
    for (int i = 0; i < count; i++) begin
      r = rand_word();
      issue_req(p, make_a(r[0], 32'h200 + {27'd0, r[3:1], 2'b00}, rand_word(),
                          (r[7:4] == 4'h0) ? 4'hf : r[7:4], {2'(p), 2'(i)}));
      repeat (int'(r[9:8]) % 3) begin
        @(posedge clk_i);
        #2;
      end
    end
  endtask

  task automatic port_reads(int p, int count);
    @(posedge clk_i);
    #2;
    for (int i = 0; i < count; i++) begin
      issue_req(p, make_a(1'b0, 32'h300 + 32'(16 * p + 4 * i), '0, 4'hf, {2'(p), 2'(i)}));
    end
  endtask

  // Memory model: grants per gnt_mode, answers in order after 1 to 4 cycles.
  initial begin
    int          key;
    logic [31:0] cur;
    mgr_rsp = '0;
    forever begin
      @(posedge clk_i);
      cycle++;
      #2;
      mgr_rsp.gnt = (gnt_mode == 1) || (gnt_mode == 0 && (rand_word() & 3) != 0);
      if (!resp_hold && rsp_ready_q.size() != 0 && rsp_ready_q[0] <= cycle) begin
        mgr_rsp.rvalid  = 1'b1;
        mgr_rsp.r.rdata = rsp_rdata_q.pop_front();
        mgr_rsp.r.rid   = rsp_rid_q.pop_front();
        mgr_rsp.r.err   = 1'b0;
        void'(rsp_ready_q.pop_front());
      end else begin
        mgr_rsp.rvalid = 1'b0;
        mgr_rsp.r      = '0;
      end
      @(negedge clk_i);
      if (mgr_req.req && mgr_rsp.gnt) begin
        key = int'(mgr_req.a.addr[31:2]);
        cur = mem_words.exists(key) ? mem_words[key] : fill_word({mgr_req.a.addr[31:2], 2'b00});
        if (mgr_req.a.we) begin
          mem_words[key] = merge_be(cur, mgr_req.a.wdata, mgr_req.a.be);
          rsp_rdata_q.push_back(32'h0);
        end else begin
          rsp_rdata_q.push_back(cur);
        end
        rsp_rid_q.push_back(mgr_req.a.aid);
        rsp_ready_q.push_back(cycle + 1 + int'(rand_word() & 3));
      end
    end
  end

  // Response checker, sampling in the middle of each cycle.
  initial begin
    int n_gnt;
    int n_rv;
    int rv_port;
    forever begin
      @(negedge clk_i);
      if (rst_done) begin
        n_gnt = 0;
        n_rv  = 0;
        for (int p = 0; p < relobi_mux_pkg::NumPorts; p++) begin
          if (sbr_rsp[p].gnt) begin
            n_gnt++;
            if (!sbr_req[p].req) begin
              $display("Port %0d was granted without a request in %s", p, test_name);
              err_count++;
            end
            exp_port_q.push_back(p);
            exp_rid_q.push_back(sbr_req[p].a.aid);
            exp_rdata_q.push_back(ref_rdata(sbr_req[p].a));
            grant_log.push_back(p);
            last_gnt = p;
          end
          if (sbr_rsp[p].rvalid) begin
            n_rv++;
            rv_port = p;
          end
        end
        if (n_gnt > 1) begin
          $display("Several ports were granted in one cycle in %s", test_name);
          err_count++;
        end
        if (n_rv > 1) begin
          $display("Several ports saw rvalid in one cycle in %s", test_name);
          err_count++;
        end else if (n_rv == 1 && exp_port_q.size() == 0) begin
          $display("A response arrived with no request outstanding in %s", test_name);
          err_count++;
        end else if (n_rv == 1) begin
          check_value("rvalid port", 64'(exp_port_q.pop_front()), 64'(rv_port));
          check_value("rid", 64'(exp_rid_q.pop_front()), 64'(sbr_rsp[rv_port].r.rid));
          check_value("rdata", 64'(exp_rdata_q.pop_front()), 64'(sbr_rsp[rv_port].r.rdata));
          check_value("err", 0, 64'(sbr_rsp[rv_port].r.err));
        end
        check_value("fault", 0, 64'(fault));
      end
    end
  end

  initial begin
    relobi_mux_pkg::obi_a_chan_t held_a;
    logic [31:0]                 wd;
    int                          n;
    int                          start;
    int                          first;
    rst_i   = 1'b1;
    sbr_req = '0;
    repeat (3) begin
      @(negedge clk_i);
      check_idle();
    end
    @(posedge clk_i);
    #2;
    rst_i = 1'b0;
    @(negedge clk_i);
    test_name = "after_reset";
    check_idle();
    rst_done = 1'b1;

    test_name = "write_read";
    gnt_mode  = 0;
    @(posedge clk_i);
    #2;
    for (int p = 0; p < relobi_mux_pkg::NumPorts; p++) begin
      wd = rand_word();
      issue_req(p, make_a(1'b1, 32'h100 + 32'(16 * p), wd, 4'hf, {2'(p), 2'd0}));
      issue_req(p, make_a(1'b1, 32'h100 + 32'(16 * p), ~wd, 4'b0101, {2'(p), 2'd1}));
      issue_req(p, make_a(1'b0, 32'h100 + 32'(16 * p), '0, 4'hf, {2'(p), 2'd2}));
      issue_req(p, make_a(1'b0, 32'h104 + 32'(16 * p), '0, 4'hf, {2'(p), 2'd3}));
    end
    drain_wait();

    if (timeout_count == 0) begin
      test_name = "rotation";
      gnt_mode  = 1;
      start     = grant_log.size();
      first     = (last_gnt + 1) % 4;
      fork
        port_reads(0, 4);
        port_reads(1, 4);
        port_reads(2, 4);
        port_reads(3, 4);
      join
      drain_wait();
      check_value("grant count", 16, 64'(grant_log.size() - start));
      for (int i = 0; i < 16 && start + i < grant_log.size(); i++) begin
        check_value($sformatf("grant %0d", i), 64'((first + i) % 4), 64'(grant_log[start + i]));
      end
    end

    if (timeout_count == 0) begin
      test_name = "withhold_gnt";
      gnt_mode  = 2;
      held_a    = make_a(1'b1, 32'h180, 32'hcafe_0001, 4'hf, 4'h5);
      fork
        begin
          @(posedge clk_i);
          #2;
          issue_req(1, held_a);
        end
        begin
          // Port 0 comes first in priority, so only the lock keeps port 1 selected.
          @(posedge clk_i);
          @(posedge clk_i);
          #2;
          issue_req(0, make_a(1'b0, 32'h184, '0, 4'hf, 4'h6));
        end
        begin
          n = 0;
          while (!mgr_req.req && n < Timeout) begin
            @(negedge clk_i);
            n++;
          end
          repeat (5) begin
            @(negedge clk_i);
            check_value("mgr req", 1, 64'(mgr_req.req));
            check_value("mgr a", 64'(held_a), 64'(mgr_req.a));
            check_value("gnt[0]", 0, 64'(sbr_rsp[0].gnt));
            check_value("gnt[1]", 0, 64'(sbr_rsp[1].gnt));
          end
          gnt_mode = 1;
        end
      join
      drain_wait();
    end

    if (timeout_count == 0) begin
      test_name = "fifo_full";
      resp_hold = 1'b1;
      fork
        port_reads(0, 2);
        port_reads(1, 1);
        port_reads(2, 1);
        port_reads(3, 1);
        begin
          n = 0;
          while (rsp_ready_q.size() < 4 && n < Timeout) begin
            @(negedge clk_i);
            n++;
          end
          @(negedge clk_i);
          check_value("outstanding", 4, 64'(rsp_ready_q.size()));
          check_value("mgr req while full", 0, 64'(mgr_req.req));
          resp_hold = 1'b0;
          n = 0;
          while (!mgr_req.req && n < Timeout) begin
            @(negedge clk_i);
            n++;
          end
          if (!mgr_req.req) begin
            $display("Manager request did not return after a response in %s", test_name);
            err_count++;
          end
        end
      join
      drain_wait();
    end

    if (timeout_count == 0) begin
      test_name = "random";
      gnt_mode  = 0;
      fork
        port_random(0, 24);
        port_random(1, 24);
        port_random(2, 24);
        port_random(3, 24);
      join
      drain_wait();
    end

    $display("check errors: %0d, timeouts: %0d", err_count, timeout_count);
    if (err_count == 0 && timeout_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
src/relobi_mux_pkg.sv
src/tmr_voter.sv
src/rr_arbiter.sv
src/index_fifo.sv
src/route_lane.sv
src/relobi_mux.sv
test/relobi_mux_asserts.sv
test/tb_relobi_mux.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the multiplexer testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f flist.f \
  --top-module tb_relobi_mux

./obj_dir/Vtb_relobi_mux > sim.log 2>&1
cat sim.log

if grep -q "sim failed" sim.log; then
  exit 1
fi
exit 0
